/* src/stm_pkg.sv */
`default_nettype none

package stm_pkg;

  localparam int NUM_SEGMENT = 2;
  localparam int MAX_CYCLE = 16;

  typedef logic [$clog2(NUM_SEGMENT)-1:0] seg_t;
  typedef logic [$clog2(MAX_CYCLE)-1:0] idx_t;

  typedef enum logic {
    MODE_GAIN  = 1'b0,
    MODE_FOCUS = 1'b1
  } stm_mode_t;

  typedef enum logic {
    TRANS_IMMEDIATE = 1'b0,
    TRANS_SYNC_IDX  = 1'b1
  } trans_mode_t;

  typedef enum logic {
    TARGET_GAIN  = 1'b0,
    TARGET_FOCUS = 1'b1
  } wr_target_t;

  // Per segment, 44 bits
  typedef struct packed {
    stm_mode_t   mode;
    idx_t        cycle;
    logic [15:0] freq_div;
    logic [7:0]  rep;
    logic [7:0]  wavenum;
    logic [6:0]  pad;
  } seg_cfg_t;

  typedef struct packed {
    logic                         update;
    seg_t                         req_segment;
    trans_mode_t                  transition_mode;
    seg_cfg_t [NUM_SEGMENT-1:0]   seg;
  } stm_settings_t;

  typedef struct packed {
    logic        en;
    wr_target_t  target;
    seg_t        segment;
    idx_t        idx;
    logic [7:0]  trans;
    logic [23:0] data;
  } stm_wr_t;

  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } gain_entry_t;

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] intensity;
  } focus_entry_t;

endpackage

`default_nettype wire

/* src/stm_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_ram #(
  parameter type entry_t = logic [15:0],
  parameter int  DEPTH   = 256
) (
  input  logic                     CLK,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  entry_t                   wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output entry_t                   rdata
);

  entry_t mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    // Registered read port
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* src/stm_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_timer (
  input  logic                                       CLK,
  input  logic                                       arst_n,
  input  stm_pkg::stm_settings_t                     settings,
  output stm_pkg::idx_t [stm_pkg::NUM_SEGMENT-1:0]   idx_per_seg,
  output logic                                       update_out
);

  import stm_pkg::*;

  logic [15:0] div_cnt [NUM_SEGMENT];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      update_out <= 1'b0;
      idx_per_seg <= '0;
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        div_cnt[s] <= '0;
      end
    end else begin
      update_out <= settings.update;
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        if (settings.update) begin
          // Counters are aligned by the time update_out is seen
          div_cnt[s] <= '0;
          idx_per_seg[s] <= '0;
        end else if (div_cnt[s] >= settings.seg[s].freq_div) begin
          div_cnt[s] <= '0;
          if (idx_per_seg[s] >= settings.seg[s].cycle) begin
            idx_per_seg[s] <= '0;
          end else begin
            idx_per_seg[s] <= idx_per_seg[s] + 1'b1;
          end
        end else begin
          div_cnt[s] <= div_cnt[s] + 16'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/stm_swapchain.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_swapchain (
  input  logic                                       CLK,
  input  logic                                       arst_n,
  input  logic                                       update_settings,
  input  stm_pkg::stm_settings_t                     settings,
  input  stm_pkg::idx_t [stm_pkg::NUM_SEGMENT-1:0]   sync_idx,
  output stm_pkg::seg_t                              segment,
  output stm_pkg::idx_t                              idx,
  output logic                                       stop
);

  import stm_pkg::*;

  seg_t                       req_segment;
  logic                       pending;
  logic [7:0]                 rep_cnt;
  logic [7:0]                 rep;
  idx_t [NUM_SEGMENT-1:0]     prev_idx;
  logic [NUM_SEGMENT-1:0]     wrap;

  assign idx = sync_idx[segment];
  assign rep = settings.seg[segment].rep;

  // Index stepped back to 0; the restart on a settings update is not a wrap
  always_comb begin
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      wrap[s] = !update_settings && (sync_idx[s] == '0) && (prev_idx[s] != '0);
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      segment <= '0;
      req_segment <= '0;
      pending <= 1'b0;
      rep_cnt <= '0;
      stop <= 1'b0;
      prev_idx <= '0;
    end else begin
      prev_idx <= sync_idx;
      if (update_settings) begin
        rep_cnt <= '0;
        stop <= 1'b0;
        if (settings.transition_mode == TRANS_IMMEDIATE) begin
          segment <= settings.req_segment;
          pending <= 1'b0;
        end else begin
          req_segment <= settings.req_segment;
          pending <= 1'b1;
        end
      end else if (pending && wrap[req_segment]) begin
        segment <= req_segment;
        pending <= 1'b0;
        rep_cnt <= '0;
      end else if (wrap[segment] && !stop) begin
        // All ones in rep means play forever
        if (rep != 8'hff && rep_cnt == rep) begin
          stop <= 1'b1;
        end else begin
          rep_cnt <= rep_cnt + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/stm_gain.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_gain #(
  parameter int NUM_TRANS = 16
) (
  input  logic             CLK,
  input  logic             arst_n,
  input  logic             start,
  input  stm_pkg::seg_t    segment,
  input  stm_pkg::idx_t    idx,
  input  stm_pkg::stm_wr_t wr,
  output logic [7:0]       intensity,
  output logic [7:0]       phase,
  output logic             dout_valid
);

  import stm_pkg::*;

  localparam int TRANS_W = $clog2(NUM_TRANS);
  localparam int ADDR_W = $bits(seg_t) + $bits(idx_t) + TRANS_W;

  logic [TRANS_W-1:0] cnt;
  logic [TRANS_W-1:0] rd_trans;
  logic               running;
  logic               issue;
  logic               rd_valid;
  gain_entry_t        rdata;

  // Transducer 0 is read in the start cycle itself
  assign issue = start || running;
  assign rd_trans = start ? '0 : cnt;

  stm_ram #(
    .entry_t(gain_entry_t),
    .DEPTH  (2 ** ADDR_W)
  ) ram0 (
    .CLK  (CLK),
    .we   (wr.en && wr.target == TARGET_GAIN),
    .waddr({wr.segment, wr.idx, wr.trans[TRANS_W-1:0]}),
    .wdata(gain_entry_t'(wr.data[15:0])),
    .raddr({segment, idx, rd_trans}),
    .rdata(rdata)
  );

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      running <= 1'b0;
      rd_valid <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      rd_valid <= issue;
      dout_valid <= rd_valid;
      if (start) begin
        cnt <= TRANS_W'(1);
        running <= (NUM_TRANS > 1);
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == TRANS_W'(NUM_TRANS - 1)) begin
          running <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    intensity <= rdata.intensity;
    phase <= rdata.phase;
  end

endmodule

`default_nettype wire

/* src/stm_focus.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_focus #(
  parameter int NUM_TRANS = 16,
  parameter int GRID_W    = 4
) (
  input  logic             CLK,
  input  logic             arst_n,
  input  logic             start,
  input  stm_pkg::seg_t    segment,
  input  stm_pkg::idx_t    idx,
  input  logic [7:0]       wavenum,
  input  stm_pkg::stm_wr_t wr,
  output logic [7:0]       intensity,
  output logic [7:0]       phase,
  output logic             dout_valid
);

  import stm_pkg::*;

  localparam int TRANS_W = $clog2(NUM_TRANS);
  localparam int ADDR_W = $bits(seg_t) + $bits(idx_t);

  logic [TRANS_W-1:0] cnt;
  logic [TRANS_W-1:0] rd_trans;
  logic               running;
  logic               issue;
  focus_entry_t       focus;
  logic [7:0]         s1_col;
  logic [7:0]         s1_row;
  logic               s1_valid;
  logic [8:0]         s2_dist;
  logic [7:0]         s2_intensity;
  logic               s2_valid;

  function automatic logic [7:0] abs_diff(input logic [7:0] a, input logic [7:0] b);
    return (a > b) ? a - b : b - a;
  endfunction

  assign issue = start || running;
  assign rd_trans = start ? '0 : cnt;

  // One focus entry per pattern, address held while the pattern streams
  stm_ram #(
    .entry_t(focus_entry_t),
    .DEPTH  (2 ** ADDR_W)
  ) ram0 (
    .CLK  (CLK),
    .we   (wr.en && wr.target == TARGET_FOCUS),
    .waddr({wr.segment, wr.idx}),
    .wdata(focus_entry_t'(wr.data)),
    .raddr({segment, idx}),
    .rdata(focus)
  );

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      running <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      s2_valid <= s1_valid;
      dout_valid <= s2_valid;
      if (start) begin
        cnt <= TRANS_W'(1);
        running <= (NUM_TRANS > 1);
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == TRANS_W'(NUM_TRANS - 1)) begin
          running <= 1'b0;
        end
      end
    end
  end

  // Grid position, then Manhattan distance, then the wavenumber multiply
  always_ff @(posedge CLK) begin
    s1_col <= 8'(rd_trans % GRID_W);
    s1_row <= 8'(rd_trans / GRID_W);
    s2_dist <= {1'b0, abs_diff(focus.x, s1_col)} + {1'b0, abs_diff(focus.y, s1_row)};
    s2_intensity <= focus.intensity;
    phase <= 8'(wavenum * s2_dist);
    intensity <= s2_intensity;
  end

endmodule

`default_nettype wire

/* src/stm.sv */
`timescale 1ns/100ps
`default_nettype none

module stm #(
  parameter int NUM_TRANS = 16,
  parameter int GRID_W    = 4
) (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  logic                   update,
  input  stm_pkg::stm_settings_t settings,
  input  stm_pkg::stm_wr_t       wr,
  output logic [7:0]             intensity,
  output logic [7:0]             phase,
  output logic                   dout_valid
);

  import stm_pkg::*;

  idx_t [NUM_SEGMENT-1:0] timer_idx;
  logic                   update_settings;
  seg_t                   sc_segment;
  idx_t                   sc_idx;
  logic                   stop;

  stm_mode_t  mode;
  seg_t       segment;
  idx_t       idx;
  logic [7:0] wavenum;
  logic       start;

  logic [7:0] intensity_gain;
  logic [7:0] phase_gain;
  logic       dout_valid_gain;
  logic [7:0] intensity_focus;
  logic [7:0] phase_focus;
  logic       dout_valid_focus;

  stm_timer timer0 (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .settings   (settings),
    .idx_per_seg(timer_idx),
    .update_out (update_settings)
  );

  stm_swapchain swapchain0 (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .update_settings(update_settings),
    .settings       (settings),
    .sync_idx       (timer_idx),
    .segment        (sc_segment),
    .idx            (sc_idx),
    .stop           (stop)
  );

  // Stop freezes the latched pattern, streaming still restarts
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mode <= MODE_GAIN;
      segment <= '0;
      idx <= '0;
      wavenum <= '0;
      start <= 1'b0;
    end else begin
      start <= update;
      if (update && !stop) begin
        segment <= sc_segment;
        idx <= sc_idx;
        mode <= settings.seg[sc_segment].mode;
        wavenum <= settings.seg[sc_segment].wavenum;
      end
    end
  end

  stm_gain #(
    .NUM_TRANS(NUM_TRANS)
  ) gain0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .start     (start),
    .segment   (segment),
    .idx       (idx),
    .wr        (wr),
    .intensity (intensity_gain),
    .phase     (phase_gain),
    .dout_valid(dout_valid_gain)
  );

  stm_focus #(
    .NUM_TRANS(NUM_TRANS),
    .GRID_W   (GRID_W)
  ) focus0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .start     (start),
    .segment   (segment),
    .idx       (idx),
    .wavenum   (wavenum),
    .wr        (wr),
    .intensity (intensity_focus),
    .phase     (phase_focus),
    .dout_valid(dout_valid_focus)
  );

  assign intensity = (mode == MODE_GAIN) ? intensity_gain : intensity_focus;
  assign phase = (mode == MODE_GAIN) ? phase_gain : phase_focus;
  assign dout_valid = (mode == MODE_GAIN) ? dout_valid_gain : dout_valid_focus;

endmodule

`default_nettype wire

/* src/stm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_top #(
  parameter int NUM_TRANS = 16,
  parameter int GRID_W    = 4
) (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  logic                   update,
  input  stm_pkg::stm_settings_t settings,
  input  stm_pkg::stm_wr_t       wr,
  output logic [7:0]             intensity,
  output logic [7:0]             phase,
  output logic                   dout_valid
);

  stm #(
    .NUM_TRANS(NUM_TRANS),
    .GRID_W   (GRID_W)
  ) stm0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .update    (update),
    .settings  (settings),
    .wr        (wr),
    .intensity (intensity),
    .phase     (phase),
    .dout_valid(dout_valid)
  );

endmodule

`default_nettype wire

/* test/stm_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_assertions #(
  parameter int NUM_TRANS = 16
) (
  input logic CLK,
  input logic arst_n,
  input logic update,
  input logic start,
  input logic dout_valid,
  input logic stop
);

  int run_len;
  int start_fails = 0;
  int burst_fails = 0;
  int source_fails = 0;
  int reset_fails = 0;
  int fail_total;

  assign fail_total = start_fails + burst_fails + source_fails + reset_fails;

  // Length of the current valid run
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      run_len <= 0;
    end else if (dout_valid) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  start_after_update: assert property (@(posedge CLK) disable iff (!arst_n)
    update |=> start)
    else begin
      $error("start did not follow update");
      start_fails++;
    end

  start_needs_update: assert property (@(posedge CLK) disable iff (!arst_n)
    start |-> $past(update))
    else begin
      $error("start without update one cycle before");
      start_fails++;
    end

  burst_not_too_long: assert property (@(posedge CLK) disable iff (!arst_n)
    dout_valid |-> run_len < NUM_TRANS)
    else begin
      $error("dout_valid burst longer than NUM_TRANS");
      burst_fails++;
    end

  burst_full_length: assert property (@(posedge CLK) disable iff (!arst_n)
    $fell(dout_valid) |-> run_len == NUM_TRANS)
    else begin
      $error("dout_valid burst shorter than NUM_TRANS");
      burst_fails++;
    end

  // Gain and focus paths have different depths
  valid_after_start: assert property (@(posedge CLK) disable iff (!arst_n)
    $rose(dout_valid) |-> ($past(start, 2) || $past(start, 3)))
    else begin
      $error("dout_valid burst without a start before it");
      source_fails++;
    end

  quiet_in_reset: assert property (@(posedge CLK)
    !arst_n |-> (!start && !dout_valid && !stop))
    else begin
      $error("start, dout_valid or stop high during reset");
      reset_fails++;
    end

endmodule

bind stm stm_assertions #(
  .NUM_TRANS(NUM_TRANS)
) assertions0 (
  .CLK       (CLK),
  .arst_n    (arst_n),
  .update    (update),
  .start     (start),
  .dout_valid(dout_valid),
  .stop      (stop)
);

`default_nettype wire

/* test/tb_stm.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_stm;

  import stm_pkg::*;

  localparam int NUM_TRANS = 16;
  localparam int GRID_W = 4;
  localparam int TIMEOUT = 64;

  logic          CLK;
  logic          arst_n;
  logic          update;
  stm_settings_t settings;
  stm_wr_t       wr;
  logic [7:0]    intensity;
  logic [7:0]    phase;
  logic          dout_valid;

  logic [15:0] lfsr;
  int          since;
  seg_t        cur_seg;
  seg_t        exp_seg;
  idx_t        exp_idx;
  stm_mode_t   exp_mode;
  logic [7:0]  exp_wnum;
  logic [15:0] gain_mem [NUM_SEGMENT][MAX_CYCLE][NUM_TRANS];
  logic [23:0] focus_mem [NUM_SEGMENT][MAX_CYCLE];
  int          value_errs;
  int          timeout_errs;

  stm_top #(
    .NUM_TRANS(NUM_TRANS),
    .GRID_W   (GRID_W)
  ) dut0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .update    (update),
    .settings  (settings),
    .wr        (wr),
    .intensity (intensity),
    .phase     (phase),
    .dout_valid(dout_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic seg_cfg_t make_cfg(input stm_mode_t mode, input int cyc, input int fd,
                                        input logic [7:0] rep, input logic [7:0] wnum);
    seg_cfg_t c;
    c.mode = mode;
    c.cycle = idx_t'(cyc);
    c.freq_div = 16'(fd);
    c.rep = rep;
    c.wavenum = wnum;
    c.pad = '0;
    return c;
  endfunction

  // Clocks for one full pass over a segment's patterns
  function automatic int seg_len(input seg_t s);
    return (int'(settings.seg[s].cycle) + 1) * (int'(settings.seg[s].freq_div) + 1);
  endfunction

  task automatic tick();
    @(negedge CLK);
    since++;
  endtask

  task automatic load_rams();
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      for (int i = 0; i < MAX_CYCLE; i++) begin
        for (int t = 0; t < NUM_TRANS; t++) begin
          tick();
          wr.en = 1'b1;
          wr.target = TARGET_GAIN;
          wr.segment = seg_t'(s);
          wr.idx = idx_t'(i);
          wr.trans = 8'(t);
          wr.data = 24'(rand_bits(16));
          gain_mem[s][i][t] = wr.data[15:0];
        end
        tick();
        wr.target = TARGET_FOCUS;
        wr.trans = 8'd0;
        // Focus point near the grid so transducers lie on both sides of it
        wr.data = {5'd0, 3'(rand_bits(3)), 5'd0, 3'(rand_bits(3)), 8'(rand_bits(8))};
        focus_mem[s][i] = wr.data;
      end
    end
    tick();
    wr = '0;
  endtask

  task automatic apply_settings(input seg_t req, input trans_mode_t tm,
                                input seg_cfg_t c0, input seg_cfg_t c1);
    tick();
    settings.update = 1'b1;
    settings.req_segment = req;
    settings.transition_mode = tm;
    settings.seg[0] = c0;
    settings.seg[1] = c1;
    since = 0;
    tick();
    settings.update = 1'b0;
  endtask

  // Pattern that an update driven k clocks after the settings update latches
  function automatic void predict_latch(input int k);
    seg_t s;
    int   fd;
    int   cyc;
    logic stopped;
    if (settings.transition_mode == TRANS_IMMEDIATE) begin
      s = settings.req_segment;
    end else if (k >= seg_len(settings.req_segment) + 2) begin
      s = settings.req_segment;
    end else begin
      s = cur_seg;
    end
    stopped = (settings.transition_mode == TRANS_IMMEDIATE) &&
              (settings.seg[s].rep != 8'hff) &&
              (k >= (int'(settings.seg[s].rep) + 1) * seg_len(s) + 2);
    if (!stopped) begin
      fd = int'(settings.seg[s].freq_div);
      cyc = int'(settings.seg[s].cycle);
      exp_seg = s;
      exp_idx = idx_t'(((k - 1) / (fd + 1)) % (cyc + 1));
      exp_mode = settings.seg[s].mode;
      exp_wnum = settings.seg[s].wavenum;
    end
  endfunction

  // Upper byte is intensity and lower byte is phase
  function automatic logic [15:0] expected_beat(input int t);
    logic [23:0] f;
    int          dx;
    int          dy;
    logic [15:0] beat;
    if (exp_mode == MODE_GAIN) begin
      beat = gain_mem[exp_seg][exp_idx][t];
    end else begin
      f = focus_mem[exp_seg][exp_idx];
      dx = int'(f[23:16]) - (t % GRID_W);
      dy = int'(f[15:8]) - (t / GRID_W);
      if (dx < 0) begin
        dx = -dx;
      end
      if (dy < 0) begin
        dy = -dy;
      end
      beat = {f[7:0], 8'((int'(exp_wnum) * (dx + dy)) % 256)};
    end
    return beat;
  endfunction

  task automatic run_burst(input string name);
    int          lat;
    int          exp_lat;
    logic [15:0] beat;
    update = 1'b1;
    predict_latch(since);
    exp_lat = (exp_mode == MODE_GAIN) ? 3 : 4;
    tick();
    update = 1'b0;
    lat = 1;
    while (!dout_valid && lat < TIMEOUT) begin
      tick();
      lat++;
    end
    if (!dout_valid) begin
      timeout_errs++;
      $display("timeout in %s: no dout_valid within %0d cycles of update", name, TIMEOUT);
    end else begin
      assert (lat == exp_lat) else begin
        value_errs++;
        $display("mismatch %s latency: expected %0d, actual %0d", name, exp_lat, lat);
      end
      for (int t = 0; t < NUM_TRANS; t++) begin
        beat = expected_beat(t);
        assert (dout_valid) else begin
          value_errs++;
          $display("mismatch %s dout_valid beat %0d: expected 1, actual 0", name, t);
        end
        assert (intensity == beat[15:8]) else begin
          value_errs++;
          $display("mismatch %s intensity beat %0d: expected %02h, actual %02h",
                   name, t, beat[15:8], intensity);
        end
        assert (phase == beat[7:0]) else begin
          value_errs++;
          $display("mismatch %s phase beat %0d: expected %02h, actual %02h",
                   name, t, beat[7:0], phase);
        end
        tick();
      end
      assert (!dout_valid) else begin
        value_errs++;
        $display("mismatch %s dout_valid after burst: expected 0, actual 1", name);
      end
    end
  endtask

  task automatic run_scenario(input string name, input seg_t req, input trans_mode_t tm,
                              input seg_cfg_t c0, input seg_cfg_t c1, input int bursts);
    int guard;
    apply_settings(req, tm, c0, c1);
    repeat (1 + int'(rand_bits(2))) tick();
    for (int b = 0; b < bursts; b++) begin
      run_burst(name);
      repeat (int'(rand_bits(3))) tick();
    end
    // Let a pending wrap switch land before the next settings update
    guard = 0;
    while (tm == TRANS_SYNC_IDX && since < seg_len(req) + 4 && guard < 1000) begin
      tick();
      guard++;
    end
    cur_seg = req;
  endtask

  initial begin
    int       proto_errs;
    seg_cfg_t gain_cfg;
    seg_cfg_t focus_cfg;
    arst_n = 1'b0;
    update = 1'b0;
    settings = '0;
    wr = '0;
    lfsr = 16'd26;
    since = 0;
    cur_seg = '0;
    exp_seg = '0;
    exp_idx = '0;
    exp_mode = MODE_GAIN;
    exp_wnum = '0;
    value_errs = 0;
    timeout_errs = 0;
    repeat (2) @(negedge CLK);
    arst_n = 1'b1;

    load_rams();
    gain_cfg = make_cfg(MODE_GAIN, 5, 2, 8'hff, 8'd0);
    focus_cfg = make_cfg(MODE_FOCUS, 3, 1, 8'hff, 8'(rand_bits(8)));
    run_scenario("gain", 1'b0, TRANS_IMMEDIATE, gain_cfg, focus_cfg, 5);
    run_scenario("immediate", 1'b1, TRANS_IMMEDIATE, gain_cfg, focus_cfg, 5);
    run_scenario("focus", 1'b0, TRANS_IMMEDIATE,
                 make_cfg(MODE_FOCUS, 7, 1, 8'hff, 8'(rand_bits(8))), gain_cfg, 4);
    // Segment 1 wraps 16 clocks after the settings update
    run_scenario("sync", 1'b1, TRANS_SYNC_IDX, make_cfg(MODE_GAIN, 3, 0, 8'hff, 8'd0),
                 make_cfg(MODE_FOCUS, 3, 3, 8'hff, 8'(rand_bits(8))), 4);
    run_scenario("repeat", 1'b0, TRANS_IMMEDIATE, make_cfg(MODE_GAIN, 3, 0, 8'd1, 8'd0),
                 focus_cfg, 4);
    repeat (4) tick();

    proto_errs = dut0.stm0.assertions0.fail_total;
    $display("errors: value %0d, timeout %0d, protocol %0d",
             value_errs, timeout_errs, proto_errs);
    if (value_errs + timeout_errs + proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/stm_pkg.sv
src/stm_ram.sv
src/stm_timer.sv
src/stm_swapchain.sv
src/stm_gain.sv
src/stm_focus.sv
src/stm.sv
src/stm_top.sv
test/stm_assertions.sv
test/tb_stm.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the stm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_stm -f filelist.f -o sim_stm
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_stm +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation log has no pass line"
  exit 1
fi
exit 0
